// ==== src/cmd_port_proc.sv ====
/*
 * Command processor for one block port. Puts each command on the port's
 * settings bus, updates the shell SID registers and answers with a readback word.
 */
module cmd_port_proc #(
   parameter int PORT_IDX = 0
) (
   input  logic                       clk,
   input  logic                       reset,
   input  noc_ctrl_pkg::cmd_word_t    i_cmd,
   input  logic                       i_cmd_valid,
   output logic                       o_cmd_ready,
   output noc_ctrl_pkg::resp_word_t   o_resp,
   output logic                       o_resp_valid,
   input  logic                       i_resp_ready,
   output noc_ctrl_pkg::set_bus_t     o_set,
   output logic                       o_clear_seq
);

   noc_ctrl_pkg::proc_state_e          state;
   noc_ctrl_pkg::cmd_word_t            cmd_q;
   noc_ctrl_pkg::rb_sel_e              rb_sel;
   logic [noc_ctrl_pkg::SID_W-1:0]     src_sid;
   logic [noc_ctrl_pkg::SID_W-1:0]     next_dst_sid;
   logic [noc_ctrl_pkg::RB_DWIDTH-1:0] rb_mux;
   logic [noc_ctrl_pkg::RB_DWIDTH-1:0] rb_data_q;
   logic                               wr_phase;

   ///////////////////////////////////////////////////////////////////////
   // Phase sequencing
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= noc_ctrl_pkg::IDLE;
      end else begin
         case (state)
            noc_ctrl_pkg::IDLE: begin
               if (i_cmd_valid) begin
                  state <= noc_ctrl_pkg::WRITE;
               end
            end
            noc_ctrl_pkg::WRITE: state <= noc_ctrl_pkg::READ;
            noc_ctrl_pkg::READ:  state <= noc_ctrl_pkg::RESPOND;
            noc_ctrl_pkg::RESPOND: begin
               if (i_resp_ready) begin
                  state <= noc_ctrl_pkg::IDLE;
               end
            end
            default: state <= noc_ctrl_pkg::IDLE;
         endcase
      end
   end

   assign o_cmd_ready = (state == noc_ctrl_pkg::IDLE);
   assign wr_phase    = (state == noc_ctrl_pkg::WRITE);

   // Capture the accepted command for the rest of the sequence
   always_ff @(posedge clk) begin
      if (o_cmd_ready && i_cmd_valid) begin
         cmd_q <= i_cmd;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Settings bus and shell registers
   ///////////////////////////////////////////////////////////////////////
   always_comb begin
      o_set.stb   = wr_phase;
      o_set.addr  = cmd_q.addr;
      o_set.data  = cmd_q.data;
      o_clear_seq = wr_phase && (cmd_q.addr == noc_ctrl_pkg::SR_CLEAR_SEQ);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         src_sid      <= '0;
         next_dst_sid <= '0;
         rb_sel       <= noc_ctrl_pkg::RB_NOC_ID;
      end else if (wr_phase) begin
         case (cmd_q.addr)
            noc_ctrl_pkg::SR_SRC_SID:
               src_sid <= cmd_q.data[noc_ctrl_pkg::SID_W-1:0];
            noc_ctrl_pkg::SR_NEXT_DST_SID:
               next_dst_sid <= cmd_q.data[noc_ctrl_pkg::SID_W-1:0];
            noc_ctrl_pkg::SR_RB_ADDR:
               rb_sel <= noc_ctrl_pkg::rb_sel_e'(cmd_q.data[noc_ctrl_pkg::RB_SEL_W-1:0]);
            default: ;
         endcase
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Readback
   ///////////////////////////////////////////////////////////////////////

   // Sampled in READ, so a write to these registers is already visible
   always_comb begin
      case (rb_sel)
         noc_ctrl_pkg::RB_NOC_ID:
            rb_mux = noc_ctrl_pkg::NOC_ID;
         noc_ctrl_pkg::RB_GLOBAL_PARAMS:
            rb_mux = {{(noc_ctrl_pkg::RB_DWIDTH-5){1'b0}}, 5'(noc_ctrl_pkg::NUM_PORTS)};
         noc_ctrl_pkg::RB_PORT_SIDS:
            rb_mux = {src_sid, next_dst_sid, 32'd0};
         default:
            rb_mux = noc_ctrl_pkg::BAD_READBACK;
      endcase
   end

   always_ff @(posedge clk) begin
      if (state == noc_ctrl_pkg::READ) begin
         rb_data_q <= rb_mux;
      end
   end

   // Response carries this port's index and the command's sequence number
   always_comb begin
      o_resp.port    = noc_ctrl_pkg::PORT_W'(PORT_IDX);
      o_resp.seqnum  = cmd_q.seqnum;
      o_resp.rb_data = rb_data_q;
      o_resp_valid   = (state == noc_ctrl_pkg::RESPOND);
   end

endmodule

// ==== src/cmd_port_steer.sv ====
/*
 * Single-entry command buffer that steers each word to the processor named by
 * its port field. Out-of-range ports are dropped one cycle after acceptance.
 */
module cmd_port_steer (
   input  logic                                 clk,
   input  logic                                 reset,
   input  noc_ctrl_pkg::cmd_word_t              i_cmd,
   input  logic                                 i_cmd_valid,
   output logic                                 o_cmd_ready,
   output noc_ctrl_pkg::cmd_word_t              o_port_cmd,
   output logic [noc_ctrl_pkg::NUM_PORTS-1:0]   o_port_valid,
   input  logic [noc_ctrl_pkg::NUM_PORTS-1:0]   i_port_ready
);

   noc_ctrl_pkg::cmd_word_t hold_q;
   logic                    hold_valid_q;
   logic                    ready_en_q;
   logic                    out_of_range;
   logic                    hold_done;

   // One-hot decode of the held port field
   always_comb begin
      for (int p = 0; p < noc_ctrl_pkg::NUM_PORTS; p++) begin
         o_port_valid[p] = hold_valid_q &&
                           (hold_q.port == noc_ctrl_pkg::PORT_W'(p));
      end
   end

   assign out_of_range = hold_q.port >= noc_ctrl_pkg::PORT_W'(noc_ctrl_pkg::NUM_PORTS);

   // Held word leaves when its processor takes it, or at once if it has no port
   assign hold_done   = hold_valid_q && (out_of_range || |(o_port_valid & i_port_ready));
   assign o_cmd_ready = ready_en_q && (!hold_valid_q || hold_done);
   assign o_port_cmd  = hold_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         hold_valid_q <= 1'b0;
         ready_en_q   <= 1'b0;
      end else begin
         ready_en_q <= 1'b1;
         if (i_cmd_valid && o_cmd_ready) begin
            hold_valid_q <= 1'b1;
         end else if (hold_done) begin
            hold_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_cmd_valid && o_cmd_ready) begin
         hold_q <= i_cmd;
      end
   end

endmodule

// ==== src/noc_ctrl_pkg.sv ====
/*
 * Shared widths, register map, enums and bus structs for the control-sink shell.
 * Every RTL file refers to these by scoped name.
 */
package noc_ctrl_pkg;

   ///////////////////////////////////////////////////////////////////////
   // Sizes
   ///////////////////////////////////////////////////////////////////////
   localparam int NUM_PORTS  = 4;
   localparam int PORT_W     = 4;
   localparam int PORT_IDX_W = $clog2(NUM_PORTS);
   localparam int SEQ_W      = 12;
   localparam int SR_AWIDTH  = 8;
   localparam int SR_DWIDTH  = 32;
   localparam int RB_DWIDTH  = 64;
   localparam int SID_W      = 16;
   localparam int RB_SEL_W   = 3;

   // Block identifier returned by the NOC_ID readback
   localparam logic [RB_DWIDTH-1:0] NOC_ID = 64'hC7A1_0000_5E77_0001;

   ///////////////////////////////////////////////////////////////////////
   // Settings addresses claimed by the shell
   ///////////////////////////////////////////////////////////////////////
   localparam logic [SR_AWIDTH-1:0] SR_RB_ADDR      = 8'd124;
   localparam logic [SR_AWIDTH-1:0] SR_SRC_SID      = 8'd128;
   localparam logic [SR_AWIDTH-1:0] SR_NEXT_DST_SID = 8'd129;
   localparam logic [SR_AWIDTH-1:0] SR_CLEAR_SEQ    = 8'd130;

   // Answer for a readback select nobody decodes
   localparam logic [RB_DWIDTH-1:0] BAD_READBACK = 64'h0BAD_C0DE_0BAD_C0DE;

   // Readback selects, written through SR_RB_ADDR
   typedef enum logic [RB_SEL_W-1:0] {
      RB_NOC_ID        = 3'd0,
      RB_GLOBAL_PARAMS = 3'd1,
      RB_PORT_SIDS     = 3'd2
   } rb_sel_e;

   // Per-port command processor phases
   typedef enum logic [1:0] {
      IDLE,
      WRITE,
      READ,
      RESPOND
   } proc_state_e;

   ///////////////////////////////////////////////////////////////////////
   // Bus words
   ///////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [PORT_W-1:0]    port;
      logic [SEQ_W-1:0]     seqnum;
      logic [SR_AWIDTH-1:0] addr;
      logic [7:0]           reserved;
      logic [SR_DWIDTH-1:0] data;
   } cmd_word_t;

   typedef struct packed {
      logic [PORT_W-1:0]    port;
      logic [SEQ_W-1:0]     seqnum;
      logic [RB_DWIDTH-1:0] rb_data;
   } resp_word_t;

   typedef struct packed {
      logic                 stb;
      logic [SR_AWIDTH-1:0] addr;
      logic [SR_DWIDTH-1:0] data;
   } set_bus_t;

endpackage

// ==== src/noc_ctrl_shell.sv ====
/*
 * Control-sink top level. Commands are steered to one processor per block port
 * and the responses are merged back onto a single output stream.
 */
module noc_ctrl_shell (
   input  logic                                 clk,
   input  logic                                 reset,
   input  noc_ctrl_pkg::cmd_word_t              i_cmd,
   input  logic                                 i_cmd_valid,
   output logic                                 o_cmd_ready,
   output noc_ctrl_pkg::resp_word_t             o_resp,
   output logic                                 o_resp_valid,
   input  logic                                 i_resp_ready,
   output noc_ctrl_pkg::set_bus_t               o_set [noc_ctrl_pkg::NUM_PORTS],
   output logic [noc_ctrl_pkg::NUM_PORTS-1:0]   o_clear_seq
);

   noc_ctrl_pkg::cmd_word_t               port_cmd;
   logic [noc_ctrl_pkg::NUM_PORTS-1:0]    port_valid;
   logic [noc_ctrl_pkg::NUM_PORTS-1:0]    port_ready;
   noc_ctrl_pkg::resp_word_t              proc_resp [noc_ctrl_pkg::NUM_PORTS];
   logic [noc_ctrl_pkg::NUM_PORTS-1:0]    proc_resp_valid;
   logic [noc_ctrl_pkg::NUM_PORTS-1:0]    proc_resp_ready;

   cmd_port_steer u_steer (
      .clk          (clk),
      .reset        (reset),
      .i_cmd        (i_cmd),
      .i_cmd_valid  (i_cmd_valid),
      .o_cmd_ready  (o_cmd_ready),
      .o_port_cmd   (port_cmd),
      .o_port_valid (port_valid),
      .i_port_ready (port_ready)
   );

   // One processor per block port, all sharing the steered command bus
   for (genvar p = 0; p < noc_ctrl_pkg::NUM_PORTS; p++) begin : g_port
      cmd_port_proc #(.PORT_IDX(p)) u_proc (
         .clk          (clk),
         .reset        (reset),
         .i_cmd        (port_cmd),
         .i_cmd_valid  (port_valid[p]),
         .o_cmd_ready  (port_ready[p]),
         .o_resp       (proc_resp[p]),
         .o_resp_valid (proc_resp_valid[p]),
         .i_resp_ready (proc_resp_ready[p]),
         .o_set        (o_set[p]),
         .o_clear_seq  (o_clear_seq[p])
      );
   end

   resp_arbiter u_arb (
      .clk          (clk),
      .reset        (reset),
      .i_resp       (proc_resp),
      .i_resp_valid (proc_resp_valid),
      .o_resp_ready (proc_resp_ready),
      .o_resp       (o_resp),
      .o_resp_valid (o_resp_valid),
      .i_resp_ready (i_resp_ready)
   );

endmodule

// ==== src/resp_arbiter.sv ====
/*
 * Round-robin merge of the per-port responses onto one valid/ready stream.
 * The grant is held while the output is stalled so the word stays stable.
 */
module resp_arbiter (
   input  logic                                 clk,
   input  logic                                 reset,
   input  noc_ctrl_pkg::resp_word_t             i_resp [noc_ctrl_pkg::NUM_PORTS],
   input  logic [noc_ctrl_pkg::NUM_PORTS-1:0]   i_resp_valid,
   output logic [noc_ctrl_pkg::NUM_PORTS-1:0]   o_resp_ready,
   output noc_ctrl_pkg::resp_word_t             o_resp,
   output logic                                 o_resp_valid,
   input  logic                                 i_resp_ready
);

   logic [noc_ctrl_pkg::PORT_IDX_W-1:0] ptr_q;
   logic [noc_ctrl_pkg::PORT_IDX_W-1:0] lock_idx_q;
   logic                                locked_q;
   logic [noc_ctrl_pkg::PORT_IDX_W-1:0] grant_idx;
   logic [noc_ctrl_pkg::PORT_IDX_W-1:0] scan_idx;
   logic                                found;

   // First valid port at or after the pointer, unless a stalled grant is pending
   always_comb begin
      found     = 1'b0;
      grant_idx = ptr_q;
      scan_idx  = ptr_q;
      for (int i = 0; i < noc_ctrl_pkg::NUM_PORTS; i++) begin
         scan_idx = noc_ctrl_pkg::PORT_IDX_W'((int'(ptr_q) + i) % noc_ctrl_pkg::NUM_PORTS);
         if (!found && i_resp_valid[scan_idx]) begin
            found     = 1'b1;
            grant_idx = scan_idx;
         end
      end
      if (locked_q) begin
         found     = 1'b1;
         grant_idx = lock_idx_q;
      end
   end

   assign o_resp_valid = found;
   assign o_resp       = i_resp[grant_idx];

   always_comb begin
      o_resp_ready = '0;
      o_resp_ready[grant_idx] = found && i_resp_ready;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ptr_q      <= '0;
         locked_q   <= 1'b0;
         lock_idx_q <= '0;
      end else begin
         locked_q   <= found && !i_resp_ready;
         lock_idx_q <= grant_idx;
         if (found && i_resp_ready) begin
            ptr_q <= (grant_idx == noc_ctrl_pkg::PORT_IDX_W'(noc_ctrl_pkg::NUM_PORTS - 1)) ?
                     '0 : grant_idx + 1'b1;
         end
      end
   end

endmodule

// ==== verif/noc_ctrl_checker.sv ====
/*
 * Testbench checker for the control-sink shell. Models the per-port shell
 * registers, compares settings pulses and responses, and reports each test.
 */
module noc_ctrl_checker (
   input  logic                                 clk,
   input  logic                                 reset,
   input  noc_ctrl_pkg::cmd_word_t              i_cmd,
   input  logic                                 i_cmd_valid,
   input  logic                                 i_cmd_ready,
   input  noc_ctrl_pkg::resp_word_t             i_resp,
   input  logic                                 i_resp_valid,
   input  logic                                 i_resp_ready,
   input  noc_ctrl_pkg::set_bus_t               i_set [noc_ctrl_pkg::NUM_PORTS],
   input  logic [noc_ctrl_pkg::NUM_PORTS-1:0]   i_clear_seq,
   input  logic                                 i_test_end,
   input  int                                   i_test_id,
   output int                                   o_err_count,
   output int                                   o_pass_count,
   output int                                   o_fail_count,
   output int                                   o_outstanding
);
   timeunit 1ns;
   timeprecision 1ps;

   // Commands waiting for their settings pulse, then responses waiting to leave
   noc_ctrl_pkg::cmd_word_t  pend_cmd [$];
   noc_ctrl_pkg::resp_word_t exp_resp [$];
   logic [15:0]              src_sid_m [noc_ctrl_pkg::NUM_PORTS];
   logic [15:0]              dst_sid_m [noc_ctrl_pkg::NUM_PORTS];
   logic [2:0]               rb_sel_m  [noc_ctrl_pkg::NUM_PORTS];
   noc_ctrl_pkg::resp_word_t last_resp;
   logic                     stalled;
   int                       errors = 0;
   int                       errors_at_start = 0;
   int                       passes = 0;
   int                       fails = 0;
   int                       accepted = 0;
   int                       answered = 0;

   assign o_err_count   = errors;
   assign o_pass_count  = passes;
   assign o_fail_count  = fails;
   assign o_outstanding = accepted - answered;

   function automatic logic [63:0] expected_readback(input logic [2:0] sel,
                                                     input logic [15:0] src,
                                                     input logic [15:0] dst);
      case (sel)
         noc_ctrl_pkg::RB_NOC_ID:        return noc_ctrl_pkg::NOC_ID;
         noc_ctrl_pkg::RB_GLOBAL_PARAMS: return 64'(noc_ctrl_pkg::NUM_PORTS);
         noc_ctrl_pkg::RB_PORT_SIDS:     return {src, dst, 32'h0};
         default:                        return noc_ctrl_pkg::BAD_READBACK;
      endcase
   endfunction

   function automatic string test_name(input int id);
      case (id)
         0:       return "sid_registers";
         1:       return "fixed_readback";
         2:       return "clear_seq";
         3:       return "out_of_range";
         default: return "random_mix";
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////
   // Settings bus: oldest waiting command of this port must match
   ////////////////////////////////////////////////////////////////////
   task automatic check_settings(input int p);
      int                       idx;
      noc_ctrl_pkg::cmd_word_t  c;
      noc_ctrl_pkg::resp_word_t r;
      idx = -1;
      for (int i = 0; i < pend_cmd.size(); i++) begin
         if (idx < 0 && pend_cmd[i].port == p) idx = i;
      end
      if (idx < 0) begin
         $display("Settings pulse on port %0d with no command waiting for it", p);
         errors++;
      end else begin
         c = pend_cmd[idx];
         pend_cmd.delete(idx);
         if (i_set[p].addr !== c.addr) begin
            $display("Error: o_set[%0d].addr expected %h got %h", p, c.addr, i_set[p].addr);
            errors++;
         end
         if (i_set[p].data !== c.data) begin
            $display("Error: o_set[%0d].data expected %h got %h", p, c.data, i_set[p].data);
            errors++;
         end
         if (i_clear_seq[p] !== (c.addr == noc_ctrl_pkg::SR_CLEAR_SEQ)) begin
            $display("Error: o_clear_seq[%0d] expected %h got %h", p,
                     c.addr == noc_ctrl_pkg::SR_CLEAR_SEQ, i_clear_seq[p]);
            errors++;
         end
         // Register update takes effect before the readback is taken
         case (c.addr)
            noc_ctrl_pkg::SR_SRC_SID:      src_sid_m[p] = c.data[15:0];
            noc_ctrl_pkg::SR_NEXT_DST_SID: dst_sid_m[p] = c.data[15:0];
            noc_ctrl_pkg::SR_RB_ADDR:      rb_sel_m[p]  = c.data[2:0];
            default: ;
         endcase
         r.port    = 4'(p);
         r.seqnum  = c.seqnum;
         r.rb_data = expected_readback(rb_sel_m[p], src_sid_m[p], dst_sid_m[p]);
         exp_resp.push_back(r);
      end
   endtask

   // Responses match by port, in command order within that port
   task automatic check_response();
      int                       idx;
      noc_ctrl_pkg::resp_word_t r;
      idx = -1;
      for (int i = 0; i < exp_resp.size(); i++) begin
         if (idx < 0 && exp_resp[i].port == i_resp.port) idx = i;
      end
      answered++;
      if (idx < 0) begin
         $display("Response for port %0d arrived with no settled command behind it",
                  i_resp.port);
         errors++;
      end else begin
         r = exp_resp[idx];
         exp_resp.delete(idx);
         if (i_resp.seqnum !== r.seqnum) begin
            $display("Error: o_resp.seqnum port %0d expected %h got %h", r.port, r.seqnum,
                     i_resp.seqnum);
            errors++;
         end
         if (i_resp.rb_data !== r.rb_data) begin
            $display("Error: o_resp.rb_data port %0d expected %h got %h", r.port, r.rb_data,
                     i_resp.rb_data);
            errors++;
         end
      end
   endtask

   task automatic report_test();
      if (answered != accepted) begin
         $display("Response count %0d does not match in-range command count %0d",
                  answered, accepted);
         errors++;
      end
      if (pend_cmd.size() != 0 || exp_resp.size() != 0) begin
         $display("Commands left unfinished at the end of the test");
         errors++;
      end
      if (errors == errors_at_start) begin
         passes++;
         $display("Test %0d %s: passed", i_test_id, test_name(i_test_id));
      end else begin
         fails++;
         $display("Test %0d %s: failed with %0d errors", i_test_id, test_name(i_test_id),
                  errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   ////////////////////////////////////////////////////////////////////
   // Sampled mid-cycle, where every DUT signal is settled
   ////////////////////////////////////////////////////////////////////
   always @(negedge clk) begin
      if (reset) begin
         for (int p = 0; p < noc_ctrl_pkg::NUM_PORTS; p++) begin
            src_sid_m[p] = '0;
            dst_sid_m[p] = '0;
            rb_sel_m[p]  = '0;
         end
         stalled = 1'b0;
      end else begin
         if (stalled && !i_resp_valid) begin
            $display("Response valid dropped before the response was taken");
            errors++;
         end else if (stalled && i_resp !== last_resp) begin
            $display("Error: o_resp changed while stalled, expected %h got %h",
                     last_resp, i_resp);
            errors++;
         end
         for (int p = 0; p < noc_ctrl_pkg::NUM_PORTS; p++) begin
            if (i_set[p].stb) begin
               check_settings(p);
            end else if (i_clear_seq[p]) begin
               $display("Clear sequence pulse on port %0d without a settings write", p);
               errors++;
            end
         end
         if (i_resp_valid && i_resp_ready) check_response();
         if (i_cmd_valid && i_cmd_ready && i_cmd.port < noc_ctrl_pkg::NUM_PORTS) begin
            pend_cmd.push_back(i_cmd);
            accepted++;
         end
         stalled   = i_resp_valid && !i_resp_ready;
         last_resp = i_resp;
         if (i_test_end) report_test();
      end
   end

endmodule

// ==== verif/tb_noc_ctrl.sv ====
/*
 * Top-level testbench for the control-sink shell. Drives seeded random commands
 * and response back-pressure; the checker module does all the comparing.
 */
module tb_noc_ctrl;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 10;
   localparam int N_OOR      = 24;
   localparam int N_RANDOM   = 200;
   // Directed commands per port: 4 SID, 3 fixed readback, 2 clear sequence
   localparam int TOTAL_CMDS = 9 * noc_ctrl_pkg::NUM_PORTS + N_OOR + N_RANDOM;

   logic                                 clk = 1'b0;
   logic                                 reset;
   noc_ctrl_pkg::cmd_word_t              cmd;
   logic                                 cmd_valid;
   logic                                 cmd_ready;
   noc_ctrl_pkg::resp_word_t             resp;
   logic                                 resp_valid;
   logic                                 resp_ready;
   noc_ctrl_pkg::set_bus_t               set_bus [noc_ctrl_pkg::NUM_PORTS];
   logic [noc_ctrl_pkg::NUM_PORTS-1:0]   clear_seq;
   logic                                 test_end;
   int                                   test_id;
   int                                   err_count;
   int                                   pass_count;
   int                                   fail_count;
   int                                   outstanding;
   logic [noc_ctrl_pkg::SEQ_W-1:0]       seq_cnt;
   integer                               seed    = 32'hc6c9;
   // Own stream for back-pressure so it never interleaves with the commands
   integer                               bp_seed = 32'hc6c9 ^ 32'h0000_ffff;

   always #(CLK_PERIOD / 2) clk = ~clk;

   noc_ctrl_shell UUT (
      .clk          (clk),
      .reset        (reset),
      .i_cmd        (cmd),
      .i_cmd_valid  (cmd_valid),
      .o_cmd_ready  (cmd_ready),
      .o_resp       (resp),
      .o_resp_valid (resp_valid),
      .i_resp_ready (resp_ready),
      .o_set        (set_bus),
      .o_clear_seq  (clear_seq)
   );

   noc_ctrl_checker u_checker (
      .clk           (clk),
      .reset         (reset),
      .i_cmd         (cmd),
      .i_cmd_valid   (cmd_valid),
      .i_cmd_ready   (cmd_ready),
      .i_resp        (resp),
      .i_resp_valid  (resp_valid),
      .i_resp_ready  (resp_ready),
      .i_set         (set_bus),
      .i_clear_seq   (clear_seq),
      .i_test_end    (test_end),
      .i_test_id     (test_id),
      .o_err_count   (err_count),
      .o_pass_count  (pass_count),
      .o_fail_count  (fail_count),
      .o_outstanding (outstanding)
   );

   // Output ready is high about 70 percent of cycles
   always @(posedge clk) begin
      resp_ready <= ($unsigned($random(bp_seed)) % 10) < 7;
   end

   // Offer one command and hold valid until the steering stage takes it
   task automatic send_cmd(input logic [3:0] port, input logic [7:0] addr,
                           input logic [31:0] data);
      noc_ctrl_pkg::cmd_word_t c;
      c.port     = port;
      c.seqnum   = seq_cnt;
      c.addr     = addr;
      c.reserved = '0;
      c.data     = data;
      seq_cnt    = seq_cnt + 1'b1;
      cmd       <= c;
      cmd_valid <= 1'b1;
      do begin
         @(negedge clk);
      end while (!cmd_ready);
      @(posedge clk);
      cmd_valid <= 1'b0;
   endtask

   // Mostly shell addresses, the rest anywhere in the settings space
   task automatic send_random(input logic [3:0] port);
      int sel;
      sel = $unsigned($random(seed)) % 6;
      repeat ($unsigned($random(seed)) % 3) @(posedge clk);
      case (sel)
         0:       send_cmd(port, noc_ctrl_pkg::SR_RB_ADDR, $random(seed));
         1:       send_cmd(port, noc_ctrl_pkg::SR_SRC_SID, $random(seed));
         2:       send_cmd(port, noc_ctrl_pkg::SR_NEXT_DST_SID, $random(seed));
         3:       send_cmd(port, noc_ctrl_pkg::SR_CLEAR_SEQ, $random(seed));
         default: send_cmd(port, 8'($random(seed)), $random(seed));
      endcase
   endtask

   // Drain every response, then let the checker close the test
   task automatic finish_test(input int id);
      while (outstanding > 0) @(posedge clk);
      repeat (10) @(posedge clk);
      test_id  <= id;
      test_end <= 1'b1;
      @(posedge clk);
      test_end <= 1'b0;
   endtask

   initial begin
      cmd       = '0;
      cmd_valid = 1'b0;
      resp_ready = 1'b0;
      test_end  = 1'b0;
      test_id   = 0;
      seq_cnt   = '0;
      reset     = 1'b1;
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      // SID writes on every port, then one extra command each to read them back
      for (int p = 0; p < noc_ctrl_pkg::NUM_PORTS; p++) begin
         send_cmd(4'(p), noc_ctrl_pkg::SR_SRC_SID, $random(seed));
         send_cmd(4'(p), noc_ctrl_pkg::SR_NEXT_DST_SID, $random(seed));
         send_cmd(4'(p), noc_ctrl_pkg::SR_RB_ADDR, 32'(noc_ctrl_pkg::RB_PORT_SIDS));
      end
      for (int p = 0; p < noc_ctrl_pkg::NUM_PORTS; p++) begin
         send_cmd(4'(p), 8'h10, $random(seed));
      end
      finish_test(0);

      for (int p = 0; p < noc_ctrl_pkg::NUM_PORTS; p++) begin
         send_cmd(4'(p), noc_ctrl_pkg::SR_RB_ADDR, 32'(noc_ctrl_pkg::RB_NOC_ID));
         send_cmd(4'(p), noc_ctrl_pkg::SR_RB_ADDR, 32'(noc_ctrl_pkg::RB_GLOBAL_PARAMS));
         send_cmd(4'(p), noc_ctrl_pkg::SR_RB_ADDR, 32'd3 + $unsigned($random(seed)) % 5);
      end
      finish_test(1);

      for (int i = 0; i < 2 * noc_ctrl_pkg::NUM_PORTS; i++) begin
         send_cmd(4'(i % noc_ctrl_pkg::NUM_PORTS), noc_ctrl_pkg::SR_CLEAR_SEQ,
                  $random(seed));
      end
      finish_test(2);

      // Every other command names a port that does not exist
      for (int i = 0; i < N_OOR; i++) begin
         if (i % 2) begin
            send_random(4'(noc_ctrl_pkg::NUM_PORTS +
                           $unsigned($random(seed)) % (16 - noc_ctrl_pkg::NUM_PORTS)));
         end else begin
            send_random(4'($unsigned($random(seed)) % noc_ctrl_pkg::NUM_PORTS));
         end
      end
      finish_test(3);

      for (int i = 0; i < N_RANDOM; i++) begin
         send_random(4'($unsigned($random(seed)) % (noc_ctrl_pkg::NUM_PORTS + 1)));
      end
      finish_test(4);

      $display("Tests passed: %0d  failed: %0d  errors: %0d", pass_count, fail_count,
               err_count);
      if (fail_count == 0 && err_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Watchdog sized from the command count
   initial begin
      #(TOTAL_CMDS * 20 * CLK_PERIOD + 1000);
      $display("Watchdog expired with %0d responses still outstanding", outstanding);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== verilog.f ====
src/noc_ctrl_pkg.sv
src/cmd_port_steer.sv
src/cmd_port_proc.sv
src/resp_arbiter.sv
src/noc_ctrl_shell.sv
verif/noc_ctrl_checker.sv
verif/tb_noc_ctrl.sv
